//--- logic/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Width of data words and of byte addresses
`define LSU_DATA_W 32

// Default depth of the shared data RAM, in words
`define LSU_RAM_WORDS 256

// Word index width, log2 of the RAM depth
`define LSU_RAM_AW 8

`endif

//--- logic/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        LB  = 4'd0,                                  // Load byte, sign-extended
        LBU = 4'd1,                                  // Load byte, zero-extended
        LH  = 4'd2,                                  // Load half, sign-extended
        LHU = 4'd3,                                  // Load half, zero-extended
        LW  = 4'd4,                                  // Load word
        SB  = 4'd5,                                  // Store byte
        SH  = 4'd6,                                  // Store half
        SW  = 4'd7,                                  // Store word
        NOP = 4'd8                                   // No memory access
    } mem_op_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'b01,                             // Same codes as the store size of the EX stage
        SZ_HALF = 2'b10,
        SZ_WORD = 2'b11
    } mem_size_t;

    typedef struct packed {
        mem_op_t                 op;                 // Memory operation
        logic [`LSU_DATA_W-1:0]  base;               // rs1 value
        logic [`LSU_DATA_W-1:0]  offset;             // Sign-extended immediate
        logic [`LSU_DATA_W-1:0]  data;               // rs2 value for stores
    } lsu_req_t;

    typedef struct packed {
        logic                    we;                 // Register write enable
        logic [`LSU_DATA_W-1:0]  data;               // Write-back word
    } lsu_resp_t;

    typedef struct packed {
        logic                    rd;                 // Read strobe
        logic                    wr;                 // Write strobe
        logic [`LSU_DATA_W-1:0]  addr;               // Byte address
        mem_size_t               size;               // Access size
        logic [`LSU_DATA_W-1:0]  wdata;              // Low-aligned store data
    } mem_bus_t;

endpackage

//--- logic/lsu_mem_unit.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_mem_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,             // One-cycle request pulse
    input  lsu_pkg::lsu_req_t       req_data,
    output logic                    busy,            // Level while a request is held
    output lsu_pkg::mem_bus_t       bus,             // Request toward the arbiter
    input  logic                    grant,
    input  logic [`LSU_DATA_W-1:0]  rd_data,         // RAM word, same cycle
    output logic                    done,            // One-cycle completion pulse
    output lsu_pkg::lsu_resp_t      resp
);
    import lsu_pkg::*;

    lsu_req_t                 req_q;                 // Held instruction
    logic [`LSU_DATA_W-1:0]   addr;                  // Effective byte address
    logic                     is_load;
    logic                     is_store;
    mem_size_t                size;
    logic [`LSU_DATA_W-1:0]   wdata_shaped;          // Store data, upper bits cleared
    logic [`LSU_DATA_W-1:0]   lane_word;             // RAM word moved down to bit 0
    logic [`LSU_DATA_W-1:0]   load_data;             // Extended load result
    logic                     accept;
    logic                     finish;

    assign accept = req & ~busy;                     // Pulses while busy are dropped
    assign addr   = req_q.base + req_q.offset;

    // Op decode
    always_comb begin
        is_load      = 1'b0;
        is_store     = 1'b0;
        size         = SZ_WORD;
        wdata_shaped = '0;
        case (req_q.op)
            LB, LBU: begin
                is_load = 1'b1;
                size    = SZ_BYTE;
            end
            LH, LHU: begin
                is_load = 1'b1;
                size    = SZ_HALF;
            end
            LW: is_load = 1'b1;
            SB: begin
                is_store          = 1'b1;
                size              = SZ_BYTE;
                wdata_shaped[7:0] = req_q.data[7:0];     // Low byte only
            end
            SH: begin
                is_store           = 1'b1;
                size               = SZ_HALF;
                wdata_shaped[15:0] = req_q.data[15:0];   // Low half only
            end
            SW: begin
                is_store     = 1'b1;
                wdata_shaped = req_q.data;
            end
            default: ;                               // NOP, no access
        endcase
    end

    // NOP has nothing to ask for, so it retires without a grant
    assign finish = busy & (grant | ~(is_load | is_store));

    always_comb begin
        bus = '0;                                    // Idle bus when nothing held
        if (busy) begin
            bus.rd    = is_load;
            bus.wr    = is_store;
            bus.addr  = addr;
            bus.size  = size;
            bus.wdata = wdata_shaped;
        end
    end

    // Load lane select and extension
    assign lane_word = rd_data >> {addr[1:0], 3'b000};

    always_comb begin
        case (req_q.op)
            LB:      load_data = {{(`LSU_DATA_W-8){lane_word[7]}}, lane_word[7:0]};
            LBU:     load_data = {{(`LSU_DATA_W-8){1'b0}}, lane_word[7:0]};
            LH:      load_data = {{(`LSU_DATA_W-16){lane_word[15]}}, lane_word[15:0]};
            LHU:     load_data = {{(`LSU_DATA_W-16){1'b0}}, lane_word[15:0]};
            default: load_data = lane_word;          // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= finish;
            if (accept)
                busy <= 1'b1;
            else if (finish)
                busy <= 1'b0;                        // Falls with done
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req_data;
        if (finish) begin
            resp.we   <= is_load;                    // Stores never write the regfile
            resp.data <= is_load ? load_data : wdata_shaped;
        end
    end

endmodule

//--- logic/lsu_arbiter.sv
`timescale 1ns/10ps

module lsu_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::mem_bus_t  bus_0,                // Lane 0 request
    input  lsu_pkg::mem_bus_t  bus_1,                // Lane 1 request
    output logic               grant_0,
    output logic               grant_1,
    output lsu_pkg::mem_bus_t  mem_bus               // Toward the RAM
);
    import lsu_pkg::*;

    logic pend_0;
    logic pend_1;
    logic last_q;                                    // 1 when lane 1 won last

    assign pend_0 = bus_0.rd | bus_0.wr;
    assign pend_1 = bus_1.rd | bus_1.wr;

    // Loser of the previous contest goes first
    assign grant_0 = pend_0 & (~pend_1 | last_q);
    assign grant_1 = pend_1 & (~pend_0 | ~last_q);

    always_ff @(posedge clk) begin
        if (rst)
            last_q <= 1'b1;                          // Lane 0 first after reset
        else if (grant_0)
            last_q <= 1'b0;
        else if (grant_1)
            last_q <= 1'b1;
    end

    // Winner's bus to the RAM
    always_comb begin
        if (grant_0)
            mem_bus = bus_0;
        else if (grant_1)
            mem_bus = bus_1;
        else
            mem_bus = '0;                            // Idle
    end

endmodule

//--- logic/lsu_data_ram.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_data_ram #(
    parameter int DEPTH = `LSU_RAM_WORDS             // Words
) (
    input  logic                    clk,
    input  lsu_pkg::mem_bus_t       mem_bus,
    output logic [`LSU_DATA_W-1:0]  rd_data          // Asynchronous read
);
    import lsu_pkg::*;

    localparam int BYTES = `LSU_DATA_W / 8;

    logic [`LSU_DATA_W-1:0]  mem [DEPTH];
    logic [`LSU_RAM_AW-1:0]  word_idx;               // Byte address over 4
    logic [1:0]              byte_off;               // Aligned lane of the access
    logic [BYTES-1:0]        be;                     // Byte enables
    logic [`LSU_DATA_W-1:0]  lane_data;              // Store data moved into its lane

    assign word_idx = mem_bus.addr[`LSU_RAM_AW+1:2];

    always_comb begin
        case (mem_bus.size)
            SZ_BYTE: begin
                byte_off = mem_bus.addr[1:0];
                be       = BYTES'(1) << byte_off;
            end
            SZ_HALF: begin
                byte_off = {mem_bus.addr[1], 1'b0};  // Bit 0 ignored
                be       = BYTES'(3) << byte_off;
            end
            default: begin
                byte_off = 2'b00;                    // Word, low bits ignored
                be       = '1;
            end
        endcase
    end

    assign lane_data = mem_bus.wdata << {byte_off, 3'b000};

    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;                             // Zero contents for simulation
    end

    always @(posedge clk) begin
        if (mem_bus.wr)
            for (int b = 0; b < BYTES; b++)
                if (be[b])
                    mem[word_idx][b*8 +: 8] <= lane_data[b*8 +: 8];
    end

    assign rd_data = mem[word_idx];

endmodule

//--- logic/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_0,
    input  lsu_pkg::lsu_req_t   req_data_0,
    output logic                busy_0,
    output logic                done_0,
    output lsu_pkg::lsu_resp_t  resp_0,
    input  logic                req_1,
    input  lsu_pkg::lsu_req_t   req_data_1,
    output logic                busy_1,
    output logic                done_1,
    output lsu_pkg::lsu_resp_t  resp_1
);
    import lsu_pkg::*;

    mem_bus_t                bus_0;                  // Lane 0 to arbiter
    mem_bus_t                bus_1;                  // Lane 1 to arbiter
    mem_bus_t                mem_bus;                // Arbiter to RAM
    logic                    grant_0;
    logic                    grant_1;
    logic [`LSU_DATA_W-1:0]  rd_data;                // Broadcast to both lanes

    lsu_mem_unit unit_0_i (
        .clk, .rst,
        .req      (req_0),
        .req_data (req_data_0),
        .busy     (busy_0),
        .bus      (bus_0),
        .grant    (grant_0),
        .rd_data  (rd_data),
        .done     (done_0),
        .resp     (resp_0)
    );

    lsu_mem_unit unit_1_i (
        .clk, .rst,
        .req      (req_1),
        .req_data (req_data_1),
        .busy     (busy_1),
        .bus      (bus_1),
        .grant    (grant_1),
        .rd_data  (rd_data),
        .done     (done_1),
        .resp     (resp_1)
    );

    lsu_arbiter arbiter_i (.clk, .rst, .bus_0, .bus_1, .grant_0, .grant_1, .mem_bus);

    lsu_data_ram #(.DEPTH(`LSU_RAM_WORDS)) ram_i (.clk, .mem_bus, .rd_data);

endmodule

//--- verification/lsu_top_tb.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_top_tb;
    import lsu_pkg::*;

    localparam int N_STEPS        = 26;              // Table length
    localparam int TIMEOUT_CYCLES = 6 * N_STEPS + 20;
    localparam int MODEL_BYTES    = `LSU_RAM_WORDS * 4;

    // Lane 1 fields hold the ignored pulse in a bp row
    typedef struct packed {
        logic [1:0]              lanes;              // Bit n selects lane n
        logic                    bp;                 // Extra pulse on lane 0 while busy
        logic [`LSU_DATA_W-1:0]  set_bits;           // Forced into random store data
        mem_op_t                 op0;
        logic [`LSU_DATA_W-1:0]  base0;
        logic [`LSU_DATA_W-1:0]  off0;
        mem_op_t                 op1;
        logic [`LSU_DATA_W-1:0]  base1;
        logic [`LSU_DATA_W-1:0]  off1;
    } step_t;

    logic       clk;
    logic       rst;
    logic       req_0;
    logic       req_1;
    lsu_req_t   req_data_0;
    lsu_req_t   req_data_1;
    logic       busy_0;
    logic       busy_1;
    logic       done_0;
    logic       done_1;
    lsu_resp_t  resp_0;
    lsu_resp_t  resp_1;

    step_t      steps [N_STEPS];
    logic [7:0] model [MODEL_BYTES];                 // Byte view of the RAM
    integer     seed;
    logic       last_won;                            // Lane granted most recently
    int         cycle_cnt   = 0;
    int         done_cnt_0  = 0;                     // Seen done pulses
    int         done_cnt_1  = 0;
    int         exp_done_0  = 0;                     // Requests really issued
    int         exp_done_1  = 0;

    lsu_top lsu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin                      // Done pulse counters
        if (!rst) begin
            if (done_0)
                done_cnt_0 <= done_cnt_0 + 1;
            if (done_1)
                done_cnt_1 <= done_cnt_1 + 1;
        end
    end

    always @(posedge clk) begin                      // Hang guard
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout expired after %0d cycles without finishing the table", cycle_cnt);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Reference behavior of one access that also updates the model on stores
    task automatic model_access(input mem_op_t op, input logic [31:0] ea,
                                input logic [31:0] d, output lsu_resp_t exp);
        int ab;
        int ah;
        int aw;
        ab  = ea[`LSU_RAM_AW+1:0];                   // Byte
        ah  = {ea[`LSU_RAM_AW+1:1], 1'b0};           // Half with bit 0 ignored
        aw  = {ea[`LSU_RAM_AW+1:2], 2'b00};          // Word
        exp = '0;
        case (op)
            LB:  exp = '{1'b1, {{24{model[ab][7]}}, model[ab]}};
            LBU: exp = '{1'b1, {24'h0, model[ab]}};
            LH:  exp = '{1'b1, {{16{model[ah+1][7]}}, model[ah+1], model[ah]}};
            LHU: exp = '{1'b1, {16'h0, model[ah+1], model[ah]}};
            LW:  exp = '{1'b1, {model[aw+3], model[aw+2], model[aw+1], model[aw]}};
            SB: begin
                model[ab] = d[7:0];
                exp       = '{1'b0, {24'h0, d[7:0]}};    // Upper bits zeroed
            end
            SH: begin
                model[ah]   = d[7:0];
                model[ah+1] = d[15:8];
                exp         = '{1'b0, {16'h0, d[15:0]}};
            end
            SW: begin
                for (int b = 0; b < 4; b++)
                    model[aw+b] = d[b*8 +: 8];
                exp = '{1'b0, d};
            end
            default: exp = '0;                       // NOP retires with nothing
        endcase
    endtask

    // Issue one table row and wait for every lane it used
    task automatic run_step(input int idx, input step_t s);
        lsu_resp_t   exp_0;
        lsu_resp_t   exp_1;
        logic [31:0] d0;
        logic [31:0] d1;
        logic        got_0;
        logic        got_1;
        int          t_0;                            // Cycle of each done
        int          t_1;
        d0    = $random(seed) | s.set_bits;
        d1    = $random(seed) | s.set_bits;
        got_0 = ~s.lanes[0];
        got_1 = ~s.lanes[1];
        t_0   = 0;
        t_1   = 0;
        @(posedge clk);
        if (s.lanes[0]) begin
            model_access(s.op0, s.base0 + s.off0, d0, exp_0);
            req_0      <= 1'b1;
            req_data_0 <= '{s.op0, s.base0, s.off0, d0};
            exp_done_0++;
        end
        if (s.lanes[1]) begin                        // Lanes of one row touch distinct words
            model_access(s.op1, s.base1 + s.off1, d1, exp_1);
            req_1      <= 1'b1;
            req_data_1 <= '{s.op1, s.base1, s.off1, d1};
            exp_done_1++;
        end
        @(posedge clk);
        req_1 <= 1'b0;
        if (s.bp) begin
            req_0      <= 1'b1;                      // Dropped by the DUT so the model stays as is
            req_data_0 <= '{SW, s.base1, s.off1, d1};
            @(negedge clk);
            check($sformatf("step %0d busy during extra pulse", idx), busy_0, 1'b1);
            @(posedge clk);
        end
        req_0 <= 1'b0;
        while (!(got_0 && got_1)) begin
            @(negedge clk);
            if (done_0 && !got_0) begin
                check($sformatf("step %0d lane 0 we", idx), resp_0.we, exp_0.we);
                check($sformatf("step %0d lane 0 data", idx), resp_0.data, exp_0.data);
                got_0 = 1'b1;
                t_0   = cycle_cnt;
            end
            if (done_1 && !got_1) begin
                check($sformatf("step %0d lane 1 we", idx), resp_1.we, exp_1.we);
                check($sformatf("step %0d lane 1 data", idx), resp_1.data, exp_1.data);
                got_1 = 1'b1;
                t_1   = cycle_cnt;
            end
        end
        // Under contention the lane not granted last wins and the loser follows
        if (s.lanes == 2'b11) begin
            check($sformatf("step %0d first done lane", idx), t_1 < t_0, !last_won);
            check($sformatf("step %0d done spacing", idx),
                  (t_1 < t_0) ? t_0 - t_1 : t_1 - t_0, 1);
        end else if (s.lanes[0] && s.op0 != NOP) begin
            last_won = 1'b0;
        end else if (s.lanes[1] && s.op1 != NOP) begin
            last_won = 1'b1;
        end
    endtask

    initial begin
        seed       = 32'h514e;
        last_won   = 1'b1;                           // Lane 0 goes first after reset
        rst        = 1'b1;
        req_0      = 1'b0;
        req_1      = 1'b0;
        req_data_0 = '0;
        req_data_1 = '0;
        for (int i = 0; i < MODEL_BYTES; i++)
            model[i] = 8'h00;                        // RAM starts zeroed
        // lanes, bp, set_bits, op0, base0, off0, op1, base1, off1
        steps[0]  = '{2'b01, 1'b0, 32'h0, SW, 32'h100, 32'h10, NOP, 32'h0, 32'h0};
        steps[1]  = '{2'b01, 1'b0, 32'h0, LW, 32'h100, 32'h10, NOP, 32'h0, 32'h0};
        steps[2]  = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, SW, 32'h200, 32'hFFFF_FFFC};
        steps[3]  = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LW, 32'h1F0, 32'hC};
        steps[4]  = '{2'b01, 1'b0, 32'h0, SB, 32'h120, 32'h0, NOP, 32'h0, 32'h0};
        steps[5]  = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, SB, 32'h120, 32'h1};
        steps[6]  = '{2'b01, 1'b0, 32'h0, SB, 32'h120, 32'h2, NOP, 32'h0, 32'h0};
        steps[7]  = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, SB, 32'h123, 32'h0};
        steps[8]  = '{2'b01, 1'b0, 32'h0, LW, 32'h120, 32'h0, NOP, 32'h0, 32'h0};
        steps[9]  = '{2'b01, 1'b0, 32'h0, SH, 32'h130, 32'h0, NOP, 32'h0, 32'h0};
        steps[10] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, SH, 32'h130, 32'h2};
        steps[11] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LW, 32'h130, 32'h0};
        steps[12] = '{2'b01, 1'b0, 32'h8080_8080, SW, 32'h140, 32'h0, NOP, 32'h0, 32'h0};
        steps[13] = '{2'b01, 1'b0, 32'h0, LB, 32'h140, 32'h1, NOP, 32'h0, 32'h0};
        steps[14] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LBU, 32'h140, 32'h1};
        steps[15] = '{2'b01, 1'b0, 32'h0, LH, 32'h140, 32'h2, NOP, 32'h0, 32'h0};
        steps[16] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LHU, 32'h140, 32'h2};
        steps[17] = '{2'b01, 1'b0, 32'h0, LB, 32'h143, 32'h0, NOP, 32'h0, 32'h0};
        steps[18] = '{2'b11, 1'b0, 32'h0, SW, 32'h150, 32'h0, LW, 32'h140, 32'h0};
        steps[19] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LW, 32'h150, 32'h0};
        steps[20] = '{2'b11, 1'b0, 32'h0, LW, 32'h150, 32'h0, SH, 32'h160, 32'h2};
        steps[21] = '{2'b11, 1'b0, 32'h0, LH, 32'h160, 32'h2, SW, 32'h170, 32'h0};
        steps[22] = '{2'b01, 1'b0, 32'h0, NOP, 32'h0, 32'h0, NOP, 32'h0, 32'h0};
        steps[23] = '{2'b01, 1'b1, 32'h0, SW, 32'h180, 32'h0, NOP, 32'h100, 32'h10};
        steps[24] = '{2'b10, 1'b0, 32'h0, NOP, 32'h0, 32'h0, LW, 32'h110, 32'h0};
        steps[25] = '{2'b01, 1'b0, 32'h0, LW, 32'h180, 32'h0, NOP, 32'h0, 32'h0};
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin                             // Quiet outputs after reset
            @(negedge clk);
            check("busy_0 after reset", busy_0, 1'b0);
            check("busy_1 after reset", busy_1, 1'b0);
            check("done_0 after reset", done_0, 1'b0);
            check("done_1 after reset", done_1, 1'b0);
        end
        for (int i = 0; i < N_STEPS; i++)
            run_step(i, steps[i]);
        repeat (4) @(negedge clk);                   // Room for a stray done
        check("lane 0 done count", done_cnt_0, exp_done_0);
        check("lane 1 done count", done_cnt_1, exp_done_1);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- lsu.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_mem_unit.sv
logic/lsu_arbiter.sv
logic/lsu_data_ram.sv
logic/lsu_top.sv
verification/lsu_top_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_mem_unit.sv
      - logic/lsu_arbiter.sv
      - logic/lsu_data_ram.sv
      - logic/lsu_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/lsu_top_tb.sv
